//--- cache_pkg.sv
package cache_pkg;

    // Line geometry is fixed, only the set count is a parameter
    localparam int offset_bits = 5;
    localparam int addr_bits   = 32;
    localparam int line_bytes  = 2 ** offset_bits;
    localparam int line_bits   = 8 * line_bytes;

    // Byte address on both ports
    typedef logic [addr_bits-1:0] addr_t;

    // One full cache line
    typedef logic [line_bits-1:0] line_t;

    // One enable bit per byte of a line
    typedef logic [line_bytes-1:0] byte_en_t;

    // Source of data written into a data array
    typedef enum logic {
        datamux_cpu_wdata,
        datamux_mem_rdata
    } datamux_sel_t;

    // Source of the memory-side line address
    typedef enum logic [1:0] {
        addrmux_cpu_addr,
        addrmux_tag0_addr,
        addrmux_tag1_addr
    } addrmux_sel_t;

    // Controller states
    typedef enum logic [2:0] {
        idle,
        compare,
        write_back,
        wb_release,
        allocate,
        alloc_release,
        done
    } cache_state_t;

endpackage : cache_pkg

//--- cache_array.sv
module cache_array #(
    parameter int s_index = 3,
    parameter int width   = 1
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               load,
    input  logic [s_index-1:0] index,
    input  logic [width-1:0]   datain,
    output logic [width-1:0]   dataout
);

    localparam int num_sets = 2 ** s_index;

    logic [width-1:0] entries [num_sets];

    // Cleared so that every set starts invalid, clean and with LRU on way 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                entries[s] <= '0;
            end
        end else if (load) begin
            entries[index] <= datain;
        end
    end

    // Combinational read of the addressed set
    assign dataout = entries[index];

endmodule : cache_array

//--- cache_data_array.sv
module cache_data_array #(
    parameter int s_index = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::byte_en_t write_en,
    input  logic [s_index-1:0]  index,
    input  cache_pkg::line_t    datain,
    output cache_pkg::line_t    dataout
);

    localparam int num_sets = 2 ** s_index;

    cache_pkg::line_t lines [num_sets];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                lines[s] <= '0;
            end
        end else begin
            // Only the enabled bytes of the addressed line change
            for (int b = 0; b < cache_pkg::line_bytes; b++) begin
                if (write_en[b]) begin
                    lines[index][8*b +: 8] <= datain[8*b +: 8];
                end
            end
        end
    end

    assign dataout = lines[index];

endmodule : cache_data_array

//--- cache_datapath.sv
module cache_datapath #(
    parameter int s_index = 3
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  cache_pkg::addr_t        cpu_addr,
    input  cache_pkg::byte_en_t     cpu_byte_enable,

    input  cache_pkg::line_t        cpu_wdata,
    output cache_pkg::line_t        cpu_rdata,
    input  cache_pkg::line_t        mem_rdata,
    output cache_pkg::line_t        mem_wdata,
    output cache_pkg::addr_t        mem_addr,

    output logic                    hit,
    output logic                    hit_way,
    output logic                    lru_way,
    output logic                    lru_dirty,

    input  logic [1:0]              load_tag,
    input  logic [1:0]              set_valid,
    input  logic [1:0]              load_dirty,
    input  logic [1:0]              dirty_in,
    input  logic [1:0]              load_data,
    input  logic                    load_lru,
    input  logic                    lru_in,
    input  cache_pkg::datamux_sel_t datamux_sel,
    input  cache_pkg::addrmux_sel_t addrmux_sel
);

    localparam int s_tag = cache_pkg::addr_bits - cache_pkg::offset_bits - s_index;

    logic [s_index-1:0] set_index;
    logic [s_tag-1:0]   tag;

    logic [s_tag-1:0]    tag_out [2];
    logic                valid_out [2];
    logic                dirty_out [2];
    cache_pkg::line_t    data_out [2];
    cache_pkg::byte_en_t data_write_en [2];
    cache_pkg::line_t    data_in;
    logic                lru_out;
    logic [1:0]          way_matched;

    // Address split
    assign set_index = cpu_addr[cache_pkg::offset_bits +: s_index];
    assign tag       = cpu_addr[cache_pkg::addr_bits-1 -: s_tag];

    for (genvar w = 0; w < 2; w++) begin : way_g
        cache_array #(.s_index(s_index), .width(s_tag)) tag_array (
            .clk     (clk),
            .arst_n  (arst_n),
            .load    (load_tag[w]),
            .index   (set_index),
            .datain  (tag),
            .dataout (tag_out[w])
        );

        // Valid is only ever set
        cache_array #(.s_index(s_index), .width(1)) valid_array (
            .clk     (clk),
            .arst_n  (arst_n),
            .load    (set_valid[w]),
            .index   (set_index),
            .datain  (1'b1),
            .dataout (valid_out[w])
        );

        cache_array #(.s_index(s_index), .width(1)) dirty_array (
            .clk     (clk),
            .arst_n  (arst_n),
            .load    (load_dirty[w]),
            .index   (set_index),
            .datain  (dirty_in[w]),
            .dataout (dirty_out[w])
        );

        cache_data_array #(.s_index(s_index)) data_array (
            .clk      (clk),
            .arst_n   (arst_n),
            .write_en (data_write_en[w]),
            .index    (set_index),
            .datain   (data_in),
            .dataout  (data_out[w])
        );

        // CPU writes merge bytes while a fill replaces the whole line
        assign data_write_en[w] = !load_data[w] ? '0 :
                                  (datamux_sel == cache_pkg::datamux_cpu_wdata) ?
                                  cpu_byte_enable : '1;

        assign way_matched[w] = valid_out[w] && (tag_out[w] == tag);
    end

    // One LRU bit per set shared by both ways
    cache_array #(.s_index(s_index), .width(1)) lru_array (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (load_lru),
        .index   (set_index),
        .datain  (lru_in),
        .dataout (lru_out)
    );

    assign hit       = |way_matched;
    assign hit_way   = way_matched[1];
    assign lru_way   = lru_out;
    assign lru_dirty = dirty_out[lru_out];

    assign data_in   = (datamux_sel == cache_pkg::datamux_mem_rdata) ? mem_rdata : cpu_wdata;
    assign cpu_rdata = data_out[hit_way];
    assign mem_wdata = data_out[lru_way];

    // Line-aligned memory address
    always_comb begin
        unique case (addrmux_sel)
            cache_pkg::addrmux_tag0_addr:
                mem_addr = {tag_out[0], set_index, {cache_pkg::offset_bits{1'b0}}};
            cache_pkg::addrmux_tag1_addr:
                mem_addr = {tag_out[1], set_index, {cache_pkg::offset_bits{1'b0}}};
            default:
                mem_addr = {cpu_addr[cache_pkg::addr_bits-1:cache_pkg::offset_bits],
                            {cache_pkg::offset_bits{1'b0}}};
        endcase
    end

    // Control must never write the same line into both ways
    a_single_way_write: assert property (
        @(posedge clk) disable iff (!arst_n) !(&load_data)
    );

endmodule : cache_datapath

//--- cache_control.sv
module cache_control (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    cpu_req,
    input  logic                    cpu_write,
    output logic                    cpu_ack,
    output logic                    mem_req,
    output logic                    mem_write,
    input  logic                    mem_ack,

    input  logic                    hit,
    input  logic                    hit_way,
    input  logic                    lru_way,
    input  logic                    lru_dirty,

    output logic [1:0]              load_tag,
    output logic [1:0]              set_valid,
    output logic [1:0]              load_dirty,
    output logic [1:0]              dirty_in,
    output logic [1:0]              load_data,
    output logic                    load_lru,
    output logic                    lru_in,
    output cache_pkg::datamux_sel_t datamux_sel,
    output cache_pkg::addrmux_sel_t addrmux_sel
);

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t next_state;

    always_comb begin
        next_state  = state;
        load_tag    = '0;
        set_valid   = '0;
        load_dirty  = '0;
        dirty_in    = '0;
        load_data   = '0;
        load_lru    = 1'b0;
        lru_in      = ~hit_way;
        datamux_sel = cache_pkg::datamux_cpu_wdata;
        addrmux_sel = cache_pkg::addrmux_cpu_addr;

        unique case (state)
            cache_pkg::idle: begin
                if (cpu_req) begin
                    next_state = cache_pkg::compare;
                end
            end
            cache_pkg::compare: begin
                if (hit) begin
                    // LRU moves to the other way on every hit
                    load_lru = 1'b1;
                    if (cpu_write) begin
                        load_data[hit_way]  = 1'b1;
                        load_dirty[hit_way] = 1'b1;
                        dirty_in[hit_way]   = 1'b1;
                    end
                    next_state = cache_pkg::done;
                end else if (lru_dirty) begin
                    next_state = cache_pkg::write_back;
                end else begin
                    next_state = cache_pkg::allocate;
                end
            end
            cache_pkg::write_back, cache_pkg::wb_release: begin
                // Victim address rebuilt from its stored tag
                addrmux_sel = lru_way ? cache_pkg::addrmux_tag1_addr
                                      : cache_pkg::addrmux_tag0_addr;
                if (state == cache_pkg::write_back && mem_ack) begin
                    next_state = cache_pkg::wb_release;
                end else if (state == cache_pkg::wb_release && !mem_ack) begin
                    next_state = cache_pkg::allocate;
                end
            end
            cache_pkg::allocate: begin
                datamux_sel = cache_pkg::datamux_mem_rdata;
                if (mem_ack) begin
                    // Fill lands clean in the victim way
                    load_data[lru_way]  = 1'b1;
                    load_tag[lru_way]   = 1'b1;
                    set_valid[lru_way]  = 1'b1;
                    load_dirty[lru_way] = 1'b1;
                    next_state = cache_pkg::alloc_release;
                end
            end
            cache_pkg::alloc_release: begin
                if (!mem_ack) begin
                    next_state = cache_pkg::compare;
                end
            end
            cache_pkg::done: begin
                if (!cpu_req) begin
                    next_state = cache_pkg::idle;
                end
            end
            default: begin
                next_state = cache_pkg::idle;
            end
        endcase
    end

    // Handshake outputs are registered from the next state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= cache_pkg::idle;
            cpu_ack   <= 1'b0;
            mem_req   <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state     <= next_state;
            cpu_ack   <= (next_state == cache_pkg::done);
            mem_req   <= (next_state == cache_pkg::write_back) ||
                         (next_state == cache_pkg::allocate);
            mem_write <= (next_state == cache_pkg::write_back);
        end
    end

    // Memory request held until acknowledged
    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!arst_n) (mem_req && !mem_ack) |=> mem_req
    );

    // No acknowledge without a pending CPU request
    a_cpu_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) (!cpu_req && !cpu_ack) |=> !cpu_ack
    );

endmodule : cache_control

//--- cache_top.sv
module cache_top #(
    parameter int s_index = 3
) (
    input  logic                clk,
    input  logic                arst_n,

    // CPU side
    input  logic                cpu_req,
    input  logic                cpu_write,
    input  cache_pkg::addr_t    cpu_addr,
    input  cache_pkg::line_t    cpu_wdata,
    input  cache_pkg::byte_en_t cpu_byte_enable,
    output logic                cpu_ack,
    output cache_pkg::line_t    cpu_rdata,

    // Memory side
    output logic                mem_req,
    output logic                mem_write,
    output cache_pkg::addr_t    mem_addr,
    output cache_pkg::line_t    mem_wdata,
    input  logic                mem_ack,
    input  cache_pkg::line_t    mem_rdata
);

    logic                    hit;
    logic                    hit_way;
    logic                    lru_way;
    logic                    lru_dirty;
    logic [1:0]              load_tag;
    logic [1:0]              set_valid;
    logic [1:0]              load_dirty;
    logic [1:0]              dirty_in;
    logic [1:0]              load_data;
    logic                    load_lru;
    logic                    lru_in;
    cache_pkg::datamux_sel_t datamux_sel;
    cache_pkg::addrmux_sel_t addrmux_sel;

    cache_control control (
        .clk         (clk),
        .arst_n      (arst_n),
        .cpu_req     (cpu_req),
        .cpu_write   (cpu_write),
        .cpu_ack     (cpu_ack),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_ack     (mem_ack),
        .hit         (hit),
        .hit_way     (hit_way),
        .lru_way     (lru_way),
        .lru_dirty   (lru_dirty),
        .load_tag    (load_tag),
        .set_valid   (set_valid),
        .load_dirty  (load_dirty),
        .dirty_in    (dirty_in),
        .load_data   (load_data),
        .load_lru    (load_lru),
        .lru_in      (lru_in),
        .datamux_sel (datamux_sel),
        .addrmux_sel (addrmux_sel)
    );

    cache_datapath #(.s_index(s_index)) datapath (
        .clk             (clk),
        .arst_n          (arst_n),
        .cpu_addr        (cpu_addr),
        .cpu_byte_enable (cpu_byte_enable),
        .cpu_wdata       (cpu_wdata),
        .cpu_rdata       (cpu_rdata),
        .mem_rdata       (mem_rdata),
        .mem_wdata       (mem_wdata),
        .mem_addr        (mem_addr),
        .hit             (hit),
        .hit_way         (hit_way),
        .lru_way         (lru_way),
        .lru_dirty       (lru_dirty),
        .load_tag        (load_tag),
        .set_valid       (set_valid),
        .load_dirty      (load_dirty),
        .dirty_in        (dirty_in),
        .load_data       (load_data),
        .load_lru        (load_lru),
        .lru_in          (lru_in),
        .datamux_sel     (datamux_sel),
        .addrmux_sel     (addrmux_sel)
    );

endmodule : cache_top

//--- tb_cache.sv
module tb_cache;

    localparam int s_index     = 3;
    localparam int num_sets    = 2 ** s_index;
    localparam int s_tag       = cache_pkg::addr_bits - cache_pkg::offset_bits - s_index;
    localparam int num_ops     = 15;
    localparam int cycle_limit = num_ops * 20 + 50;

    logic                clk;
    logic                arst_n;
    logic                cpu_req;
    logic                cpu_write;
    cache_pkg::addr_t    cpu_addr;
    cache_pkg::line_t    cpu_wdata;
    cache_pkg::byte_en_t cpu_byte_enable;
    logic                cpu_ack;
    cache_pkg::line_t    cpu_rdata;
    logic                mem_req;
    logic                mem_write;
    cache_pkg::addr_t    mem_addr;
    cache_pkg::line_t    mem_wdata;
    logic                mem_ack;
    cache_pkg::line_t    mem_rdata;

    // Stimulus table
    logic                op_write   [num_ops];
    cache_pkg::addr_t    op_addr    [num_ops];
    cache_pkg::byte_en_t op_be      [num_ops];
    logic                op_rand    [num_ops];
    // Number of memory transactions each entry causes
    int                  op_traffic [num_ops];
    int                  num_loaded;

    // Reference model of the cache and of memory
    logic [s_tag-1:0] ref_tag   [num_sets][2];
    logic             ref_valid [num_sets][2];
    logic             ref_dirty [num_sets][2];
    logic             ref_lru   [num_sets];
    cache_pkg::line_t ref_line  [num_sets][2];
    cache_pkg::line_t ref_mem   [cache_pkg::addr_t];
    cache_pkg::line_t mem_lines [cache_pkg::addr_t];

    // Predicted and observed memory transactions
    logic             exp_write_q [$];
    cache_pkg::addr_t exp_addr_q  [$];
    cache_pkg::line_t exp_data_q  [$];
    logic             obs_write_q [$];
    cache_pkg::addr_t obs_addr_q  [$];
    cache_pkg::line_t obs_data_q  [$];

    logic [31:0] lfsr_state = 32'h43a47297;

    cache_top #(.s_index(s_index)) dut0 (
        .clk             (clk),
        .arst_n          (arst_n),
        .cpu_req         (cpu_req),
        .cpu_write       (cpu_write),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .cpu_byte_enable (cpu_byte_enable),
        .cpu_ack         (cpu_ack),
        .cpu_rdata       (cpu_rdata),
        .mem_req         (mem_req),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_ack         (mem_ack),
        .mem_rdata       (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = lfsr_step();
        end
        return value;
    endfunction

    function automatic cache_pkg::line_t random_line();
        cache_pkg::line_t value;
        for (int i = 0; i < cache_pkg::line_bits; i++) begin
            value[i] = lfsr_step();
        end
        return value;
    endfunction

    function automatic cache_pkg::addr_t line_of(input cache_pkg::addr_t addr);
        return {addr[cache_pkg::addr_bits-1:cache_pkg::offset_bits],
                {cache_pkg::offset_bits{1'b0}}};
    endfunction

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("Verification failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t expected,
                              input cache_pkg::line_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t expected,
                              input cache_pkg::addr_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %b got %b", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic add_op(input logic write, input cache_pkg::addr_t addr,
                          input cache_pkg::byte_en_t be, input logic rnd, input int traffic);
        op_write[num_loaded]   = write;
        op_addr[num_loaded]    = addr;
        op_be[num_loaded]      = be;
        op_rand[num_loaded]    = rnd;
        op_traffic[num_loaded] = traffic;
        num_loaded++;
    endtask

    task automatic load_table();
        num_loaded = 0;
        add_op(1'b0, 32'h0000_0024, '0,            1'b0, 1); // line A into set 1
        add_op(1'b0, 32'h0000_002c, '0,            1'b0, 0);
        add_op(1'b1, 32'h0000_0028, 32'h0000_0f00, 1'b1, 0); // A turns dirty
        add_op(1'b0, 32'h0000_0020, '0,            1'b0, 0);
        add_op(1'b0, 32'h0000_0120, '0,            1'b0, 1); // B into way 1
        add_op(1'b0, 32'h0000_0220, '0,            1'b0, 2); // C evicts dirty A
        add_op(1'b0, 32'h0000_0320, '0,            1'b0, 1); // D evicts clean B
        add_op(1'b0, 32'h0000_0220, '0,            1'b0, 0);
        add_op(1'b1, 32'h0000_0030, 32'h00ff_00f0, 1'b1, 1); // A back over D
        add_op(1'b0, 32'h0000_0020, '0,            1'b0, 0);
        add_op(1'b1, 32'h0000_0044, '1,            1'b0, 1); // set 2, full line write
        add_op(1'b0, 32'h0000_0040, '0,            1'b0, 0);
        add_op(1'b0, 32'h0000_0120, '0,            1'b0, 1);
        add_op(1'b0, 32'h0000_0420, '0,            1'b0, 2);
        add_op(1'b0, 32'h0000_0020, '0,            1'b0, 1);
    endtask

    // Predicts read data and memory traffic of one access
    task automatic ref_access(input logic write, input cache_pkg::addr_t addr,
                              input cache_pkg::byte_en_t be, input cache_pkg::line_t wdata,
                              output cache_pkg::line_t rdata, output int traffic);
        logic [s_index-1:0] set_idx;
        logic [s_tag-1:0]   tag;
        logic               found;
        logic               way_sel;
        cache_pkg::addr_t   victim_addr;
        set_idx = addr[cache_pkg::offset_bits +: s_index];
        tag     = addr[cache_pkg::addr_bits-1 -: s_tag];
        found   = 1'b0;
        way_sel = 1'b0;
        traffic = 0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag) begin
                found   = 1'b1;
                way_sel = w[0];
            end
        end
        if (!found) begin
            way_sel = ref_lru[set_idx];
            if (ref_valid[set_idx][way_sel] && ref_dirty[set_idx][way_sel]) begin
                victim_addr = {ref_tag[set_idx][way_sel], set_idx,
                               {cache_pkg::offset_bits{1'b0}}};
                exp_write_q.push_back(1'b1);
                exp_addr_q.push_back(victim_addr);
                exp_data_q.push_back(ref_line[set_idx][way_sel]);
                ref_mem[victim_addr] = ref_line[set_idx][way_sel];
                traffic = 1;
            end
            exp_write_q.push_back(1'b0);
            exp_addr_q.push_back(line_of(addr));
            exp_data_q.push_back('0);
            ref_line[set_idx][way_sel]  = ref_mem[line_of(addr)];
            ref_tag[set_idx][way_sel]   = tag;
            ref_valid[set_idx][way_sel] = 1'b1;
            ref_dirty[set_idx][way_sel] = 1'b0;
            traffic = traffic + 1;
        end
        if (write) begin
            for (int b = 0; b < cache_pkg::line_bytes; b++) begin
                if (be[b]) begin
                    ref_line[set_idx][way_sel][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            ref_dirty[set_idx][way_sel] = 1'b1;
        end
        rdata = ref_line[set_idx][way_sel];
        ref_lru[set_idx] = ~way_sel;
    endtask

    // One four-phase CPU transaction that starts and ends 1 unit after an edge
    task automatic cpu_access(input logic write, input cache_pkg::addr_t addr,
                              input cache_pkg::byte_en_t be, input cache_pkg::line_t wdata,
                              input logic expect_hit, output cache_pkg::line_t rdata);
        // An idle cycle without a request must not acknowledge
        @(posedge clk);
        #1;
        check_bit("cpu_ack", 1'b0, cpu_ack);
        cpu_write       = write;
        cpu_addr        = addr;
        cpu_byte_enable = be;
        cpu_wdata       = wdata;
        cpu_req         = 1'b1;
        if (expect_hit) begin
            // A hit acknowledges on the second edge
            @(posedge clk);
            #1;
            check_bit("cpu_ack", 1'b0, cpu_ack);
            @(posedge clk);
            #1;
            check_bit("cpu_ack", 1'b1, cpu_ack);
        end else begin
            do begin
                @(posedge clk);
                #1;
            end while (!cpu_ack);
        end
        check_bit("mem_req", 1'b0, mem_req);
        rdata = cpu_rdata;
        @(posedge clk);
        #1;
        check_bit("cpu_ack", 1'b1, cpu_ack);
        cpu_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (cpu_ack);
    endtask

    task automatic check_memory_traffic(input int entry);
        if (obs_addr_q.size() != exp_addr_q.size()) begin
            report_failure($sformatf("entry %0d expected %0d memory transactions but saw %0d",
                                     entry, exp_addr_q.size(), obs_addr_q.size()));
        end
        for (int t = 0; t < exp_addr_q.size(); t++) begin
            check_bit("mem_write", exp_write_q[t], obs_write_q[t]);
            check_addr("mem_addr", exp_addr_q[t], obs_addr_q[t]);
            if (exp_write_q[t]) begin
                check_line("mem_wdata", exp_data_q[t], obs_data_q[t]);
            end
        end
        exp_write_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        obs_write_q.delete();
        obs_addr_q.delete();
        obs_data_q.delete();
    endtask

    // Memory model that answers each request after 1 to 3 cycles
    initial begin
        int               delay;
        cache_pkg::addr_t addr;
        forever begin
            @(posedge clk);
            #1;
            if (arst_n && mem_req) begin
                addr = mem_addr;
                obs_write_q.push_back(mem_write);
                obs_addr_q.push_back(addr);
                obs_data_q.push_back(mem_wdata);
                if (mem_write) begin
                    mem_lines[addr] = mem_wdata;
                end
                delay = 1 + int'(random_bits(2)) % 3;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                    check_bit("mem_req", 1'b1, mem_req);
                end
                mem_rdata = mem_lines.exists(addr) ? mem_lines[addr] : '0;
                mem_ack   = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    initial begin
        int                      cycles;
        cache_pkg::cache_state_t stuck_state;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        stuck_state = dut0.control.state;
        report_failure($sformatf("the run hung for %0d cycles with the controller in %s",
                                 cycles, stuck_state.name()));
    end

    initial begin
        int               traffic;
        cache_pkg::line_t wdata;
        cache_pkg::line_t exp_rdata;
        cache_pkg::line_t act_rdata;
        arst_n          = 1'b0;
        cpu_req         = 1'b0;
        cpu_write       = 1'b0;
        cpu_addr        = '0;
        cpu_wdata       = '0;
        cpu_byte_enable = '0;
        mem_ack         = 1'b0;
        mem_rdata       = '0;
        for (int s = 0; s < num_sets; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_line[s][w]  = '0;
            end
        end
        load_table();
        // Memory holds random lines at every address the table touches
        for (int i = 0; i < num_ops; i++) begin
            if (!mem_lines.exists(line_of(op_addr[i]))) begin
                mem_lines[line_of(op_addr[i])] = random_line();
                ref_mem[line_of(op_addr[i])]   = mem_lines[line_of(op_addr[i])];
            end
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_bit("cpu_ack", 1'b0, cpu_ack);
        check_bit("mem_req", 1'b0, mem_req);
        check_bit("mem_write", 1'b0, mem_write);

        for (int i = 0; i < num_ops; i++) begin
            wdata = op_rand[i] ? random_line() : {8{~op_addr[i]}};
            ref_access(op_write[i], op_addr[i], op_be[i], wdata, exp_rdata, traffic);
            if (traffic != op_traffic[i]) begin
                report_failure($sformatf("entry %0d predicts traffic %0d but the table says %0d",
                                         i, traffic, op_traffic[i]));
            end
            cpu_access(op_write[i], op_addr[i], op_be[i], wdata, op_traffic[i] == 0, act_rdata);
            if (!op_write[i]) begin
                check_line("cpu_rdata", exp_rdata, act_rdata);
            end
            check_memory_traffic(i);
        end

        $display("Verification passed");
        $finish;
    end

endmodule : tb_cache

//--- build.f
cache_pkg.sv
cache_array.sv
cache_data_array.sv
cache_datapath.sv
cache_control.sv
cache_top.sv
tb_cache.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cache
FILELIST = build.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
